// File: src.f
+incdir+include
logic/bsc_pkg.sv
logic/bsc_hs_req.sv
logic/bsc_state.sv
logic/bsc_decode.sv
logic/bsc_alu.sv
logic/bsc_ctrl.sv
logic/bsc_rf.sv
logic/bsc_store.sv
logic/bsc_top.sv
sim/bsc_tb_assert.sv
sim/bsc_tb.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --timing --assert
TOP       := bsc_tb
FILELIST  := src.f
OBJ_DIR   := obj_dir
PASS_MSG  := TEST PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -x "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// File: sim/bsc_tb.sv
`timescale 1ns/1ps
`include "bsc_defines.svh"

module bsc_tb
   import bsc_pkg::*;
();

   localparam int          SEED       = 32'h2dc5;
   localparam int          N_MAIN     = 120;
   localparam int          N_PROG     = N_MAIN + 31;
   localparam logic [31:0] END_ADDR   = `BSC_RESET_PC + 32'(N_PROG * 4);
   localparam int          MAX_CYCLES = 140 * (N_PROG + 1) + 200;
   localparam logic [31:0] NOP        = 32'h0000_0013;

   logic        clk        = 1'b0;
   logic        rst_n      = 1'b0;
   logic        ibus_ack   = 1'b0;
   logic [31:0] ibus_rdata = '0;
   logic        dbus_ack   = 1'b0;
   logic        ibus_req;
   logic        dbus_req;
   ibus_req_t   ibus;
   dbus_req_t   dbus;

   int          gen_seed   = SEED;
   int          ibus_seed  = SEED ^ 32'h1;
   int          dbus_seed  = SEED ^ 32'h2;
   int unsigned ibus_delay = 0;
   int unsigned dbus_delay = 0;
   int          cycles     = 0;
   int          fetch_errors = 0;
   int          store_errors = 0;
   int          other_errors = 0;
   logic        done       = 1'b0;
   logic        ibus_req_q = 1'b0;
   logic        dbus_req_q = 1'b0;

   logic [31:0] imem [256];
   logic [31:0] model_regs [32];
   ibus_req_t   exp_fetch;
   logic        exp_has_store;
   dbus_req_t   exp_store;
   dbus_req_t   exp_stores [$];

   always #50 clk = ~clk;

   bsc_top bsc_top_inst (
      .clk          (clk),
      .i_rst_n      (rst_n),
      .o_ibus_req   (ibus_req),
      .o_ibus       (ibus),
      .i_ibus_ack   (ibus_ack),
      .i_ibus_rdata (ibus_rdata),
      .o_dbus_req   (dbus_req),
      .o_dbus       (dbus),
      .i_dbus_ack   (dbus_ack)
   );

   function automatic int unsigned rand_below(inout int seed, input int unsigned n);
      int unsigned r;
      r = $random(seed);
      return r % n;
   endfunction

   function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
      return {imm, rs1, f3, rd, 7'b0010011};
   endfunction

   function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic logic [2:0] alu_funct3(input logic [1:0] sel);
      case (sel)
         2'd0:    return 3'b000;
         2'd1:    return 3'b100;
         2'd2:    return 3'b110;
         default: return 3'b111;
      endcase
   endfunction

   function automatic logic [31:0] fetch_word(input logic [31:0] addr);
      logic [31:0] idx;
      idx = (addr - `BSC_RESET_PC) >> 2;
      if (idx >= 32'(N_PROG)) begin
         return NOP;
      end
      return imem[idx[7:0]];
   endfunction

   // Random body with forward branches, then a dump of x1..x31
   task automatic build_program();
      int unsigned kind;
      int unsigned span;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [2:0]  f3;
      logic [6:0]  f7;
      for (int i = 0; i < N_MAIN; i++) begin
         kind = rand_below(gen_seed, 10);
         rd   = 5'(rand_below(gen_seed, 16));
         rs1  = 5'(rand_below(gen_seed, 16));
         rs2  = 5'(rand_below(gen_seed, 16));
         f3   = alu_funct3(2'(rand_below(gen_seed, 4)));
         f7   = (f3 == 3'b000 && rand_below(gen_seed, 2) == 1) ? 7'b0100000 : 7'b0000000;
         case (kind)
            0, 1, 2: imem[8'(i)] = enc_r(f7, rs2, rs1, f3, rd);
            3, 4, 5: imem[8'(i)] = enc_i(12'(rand_below(gen_seed, 4096)), rs1, f3, rd);
            6:       imem[8'(i)] = {20'(rand_below(gen_seed, 1 << 20)), rd, 7'b0110111};
            7, 8: begin
               span = 32'(N_MAIN - i);
               if (span > 6) begin
                  span = 6;
               end
               if (rand_below(gen_seed, 3) == 0) begin
                  rs2 = rs1;
               end
               f3 = {2'b00, rand_below(gen_seed, 2) == 1};
               imem[8'(i)] = enc_b(13'(4 * (1 + rand_below(gen_seed, span))), rs2, rs1, f3);
            end
            default: imem[8'(i)] = enc_s(12'(rand_below(gen_seed, 4096)), rs2, rs1);
         endcase
      end
      for (int r = 1; r < 32; r++) begin
         imem[8'(N_MAIN + r - 1)] = enc_s(12'(4 * r), 5'(r), 5'd0);
      end
   endtask

   // ISA model of one instruction, returns the next fetch address
   function automatic logic [31:0] ref_step(input logic [31:0] insn, input logic [31:0] pc,
                                            output logic has_store, output dbus_req_t st);
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] i_imm;
      logic [31:0] s_imm;
      logic [31:0] b_imm;
      logic [31:0] opb;
      logic [31:0] res;
      logic [31:0] next;
      logic        wr;
      a     = model_regs[insn[19:15]];
      b     = model_regs[insn[24:20]];
      i_imm = {{20{insn[31]}}, insn[31:20]};
      s_imm = {{20{insn[31]}}, insn[31:25], insn[11:7]};
      b_imm = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
      opb   = (insn[6:0] == 7'b0010011) ? i_imm : b;
      res   = '0;
      wr    = 1'b0;
      next  = pc + 32'd4;
      has_store = 1'b0;
      st    = '0;
      case (insn[6:0])
         7'b0110011, 7'b0010011: begin
            wr = 1'b1;
            case (insn[14:12])
               3'b000:  res = (insn[6:0] == 7'b0110011 && insn[30]) ? a - opb : a + opb;
               3'b100:  res = a ^ opb;
               3'b110:  res = a | opb;
               default: res = a & opb;
            endcase
         end
         7'b0110111: begin
            wr  = 1'b1;
            res = {insn[31:12], 12'd0};
         end
         7'b1100011: begin
            if ((a == b) != insn[12]) begin
               next = pc + b_imm;
            end
         end
         7'b0100011: begin
            has_store = 1'b1;
            st.addr   = a + s_imm;
            st.data   = b;
         end
         default: ;
      endcase
      if (wr && insn[11:7] != 5'd0) begin
         model_regs[insn[11:7]] = res;
      end
      return next;
   endfunction

   task automatic check_fetch(input ibus_req_t got, input ibus_req_t exp);
      if (got !== exp) begin
         fetch_errors++;
         $display("Fail at %0t: fetch address %h, expected %h", $time, got.addr, exp.addr);
      end
   endtask

   task automatic check_store(input dbus_req_t got, input dbus_req_t exp);
      if (got !== exp) begin
         store_errors++;
         $display("Fail at %0t: store %h <= %h, expected %h <= %h",
                  $time, got.addr, got.data, exp.addr, exp.data);
      end
   endtask

   always @(posedge clk) begin
      if (!rst_n) begin
         ibus_ack   <= 1'b0;
         ibus_delay <= 0;
      end else if (ibus_delay != 0) begin
         ibus_delay <= ibus_delay - 1;
      end else if (ibus_req && !ibus_ack) begin
         ibus_ack   <= 1'b1;
         ibus_rdata <= fetch_word(ibus.addr);
         ibus_delay <= rand_below(ibus_seed, 8);
      end else if (!ibus_req && ibus_ack) begin
         ibus_ack   <= 1'b0;
         ibus_delay <= rand_below(ibus_seed, 8);
      end
   end

   always @(posedge clk) begin
      if (!rst_n) begin
         dbus_ack   <= 1'b0;
         dbus_delay <= 0;
      end else if (dbus_delay != 0) begin
         dbus_delay <= dbus_delay - 1;
      end else if (dbus_req && !dbus_ack) begin
         dbus_ack   <= 1'b1;
         dbus_delay <= rand_below(dbus_seed, 8);
      end else if (!dbus_req && dbus_ack) begin
         dbus_ack   <= 1'b0;
         dbus_delay <= rand_below(dbus_seed, 8);
      end
   end

   // Compare on each rising req, payload already stable
   always @(posedge clk) begin
      if (rst_n) begin
         cycles     <= cycles + 1;
         ibus_req_q <= ibus_req;
         dbus_req_q <= dbus_req;
         if (dbus_req && !dbus_req_q) begin
            if (exp_stores.size() == 0) begin
               other_errors++;
               $display("Unexpected data request at %0t to address %h", $time, dbus.addr);
            end else begin
               check_store(dbus, exp_stores.pop_front());
            end
         end
         if (ibus_req && !ibus_req_q && !done) begin
            if (exp_stores.size() != 0) begin
               other_errors++;
               $display("Store missing before the fetch at %0t", $time);
               exp_stores.delete();
            end
            check_fetch(ibus, exp_fetch);
            if (exp_fetch.addr == END_ADDR) begin
               done <= 1'b1;
            end else begin
               exp_fetch.addr = ref_step(fetch_word(exp_fetch.addr), exp_fetch.addr,
                                         exp_has_store, exp_store);
               if (exp_has_store) begin
                  exp_stores.push_back(exp_store);
               end
            end
         end
      end
   end

   initial begin
      for (int r = 0; r < 32; r++) begin
         model_regs[r] = '0;
      end
      exp_fetch.addr = `BSC_RESET_PC;
      build_program();
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      while (!done && cycles < MAX_CYCLES) begin
         @(posedge clk);
      end
      if (!done) begin
         other_errors++;
         $display("Timeout, program did not finish within %0d cycles", MAX_CYCLES);
      end
      $display("Errors: fetch %0d, store %0d, other %0d", fetch_errors, store_errors,
               other_errors);
      if (fetch_errors + store_errors + other_errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

// File: sim/bsc_tb_assert.sv
`timescale 1ns/1ps

module bsc_tb_assert (
   input logic        clk,
   input logic        i_rst_n,
   input logic        i_req,
   input logic        i_ack,
   input logic [63:0] i_payload,
   input logic [4:0]  i_cnt,
   input logic        i_cnt_en
);

   // Four-phase requester side
   req_held: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_req && !i_ack |=> i_req)
      else $error("req dropped before ack");

   req_wait_release: assert property (@(posedge clk) disable iff (!i_rst_n)
      !i_req && i_ack |=> !i_req)
      else $error("req raised while ack still high");

   payload_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_req && $past(i_req) |-> $stable(i_payload))
      else $error("payload changed while req high");

   // Bit counter
   cnt_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
      !i_cnt_en |=> $stable(i_cnt))
      else $error("cnt moved without cnt_en");

endmodule

bind bsc_hs_req bsc_tb_assert hs_assert_inst (
   .clk       (clk),
   .i_rst_n   (i_rst_n),
   .i_req     (o_req),
   .i_ack     (i_ack),
   .i_payload (64'(o_payload)),
   .i_cnt     (5'd0),
   .i_cnt_en  (1'b0)
);

bind bsc_state bsc_tb_assert state_assert_inst (
   .clk       (clk),
   .i_rst_n   (i_rst_n),
   .i_req     (1'b0),
   .i_ack     (1'b0),
   .i_payload (64'd0),
   .i_cnt     (o_cnt),
   .i_cnt_en  (o_cnt_en)
);

// File: logic/bsc_top.sv
`timescale 1ns/1ps
`include "bsc_defines.svh"

module bsc_top
   import bsc_pkg::*;
(
   input  logic                 clk,
   input  logic                 i_rst_n,
   output logic                 o_ibus_req,
   output ibus_req_t            o_ibus,
   input  logic                 i_ibus_ack,
   input  logic [`BSC_XLEN-1:0] i_ibus_rdata,
   output logic                 o_dbus_req,
   output dbus_req_t            o_dbus,
   input  logic                 i_dbus_ack
);

   phase_e               phase;
   dec_ctrl_t            ctrl;
   ibus_req_t            fetch_req;
   logic [`BSC_XLEN-1:0] pc;
   logic [4:0]           cnt;
   logic                 cnt_en;
   logic                 fetch_start;
   logic                 fetch_done;
   logic                 store_start;
   logic                 store_done;
   logic                 ir_load;
   logic                 rd_wen;
   logic                 imm;
   logic                 rs1;
   logic                 rs2;
   logic                 rd_bit;
   logic                 sum_bit;
   logic                 cmp_eq;
   logic                 take;

   assign fetch_req.addr = pc;

   // BEQ on equal, BNE on mismatch
   assign take = ctrl.is_branch && (cmp_eq ^ ctrl.branch_ne);

   bsc_state state_inst (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_ctrl        (ctrl),
      .i_fetch_done  (fetch_done),
      .i_store_done  (store_done),
      .i_ibus_ack    (i_ibus_ack),
      .o_phase       (phase),
      .o_cnt         (cnt),
      .o_cnt_en      (cnt_en),
      .o_fetch_start (fetch_start),
      .o_store_start (store_start),
      .o_ir_load     (ir_load),
      .o_rd_wen      (rd_wen)
   );

   bsc_decode decode_inst (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_ir_load    (ir_load),
      .i_ibus_rdata (i_ibus_rdata),
      .i_phase      (phase),
      .i_cnt_en     (cnt_en),
      .o_ctrl       (ctrl),
      .o_imm        (imm)
   );

   bsc_alu alu_inst (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .i_ctrl   (ctrl),
      .i_cnt    (cnt),
      .i_cnt_en (cnt_en),
      .i_rs1    (rs1),
      .i_rs2    (rs2),
      .i_imm    (imm),
      .o_rd     (rd_bit),
      .o_sum    (sum_bit),
      .o_cmp_eq (cmp_eq)
   );

   bsc_ctrl ctrl_inst (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_cnt   (cnt),
      .i_pcupd (phase == PH_PCUPD),
      .i_imm   (imm),
      .i_take  (take),
      .o_pc    (pc)
   );

   bsc_rf rf_inst (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_cnt      (cnt),
      .i_rs1_addr (ctrl.rs1),
      .i_rs2_addr (ctrl.rs2),
      .i_rd_addr  (ctrl.rd),
      .i_wen      (rd_wen),
      .i_rd       (rd_bit),
      .o_rs1      (rs1),
      .o_rs2      (rs2)
   );

   bsc_store store_inst (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_cnt      (cnt),
      .i_capture  ((phase == PH_EXEC) && ctrl.is_store),
      .i_sum      (sum_bit),
      .i_rs2      (rs2),
      .i_start    (store_start),
      .o_dbus_req (o_dbus_req),
      .o_dbus     (o_dbus),
      .i_dbus_ack (i_dbus_ack),
      .o_done     (store_done)
   );

   bsc_hs_req #(
      .payload_t (ibus_req_t)
   ) ibus_req_inst (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_start   (fetch_start),
      .i_payload (fetch_req),
      .o_req     (o_ibus_req),
      .o_payload (o_ibus),
      .i_ack     (i_ibus_ack),
      .o_done    (fetch_done)
   );

endmodule

// File: logic/bsc_store.sv
`timescale 1ns/1ps

module bsc_store
   import bsc_pkg::*;
(
   input  logic       clk,
   input  logic       i_rst_n,
   input  logic [4:0] i_cnt,
   input  logic       i_capture,
   input  logic       i_sum,
   input  logic       i_rs2,
   input  logic       i_start,
   output logic       o_dbus_req,
   output dbus_req_t  o_dbus,
   input  logic       i_dbus_ack,
   output logic       o_done
);

   dbus_req_t wr_q;

   // Address and data assembled bit by bit during EXEC
   always_ff @(posedge clk) begin
      if (i_capture) begin
         wr_q.addr[i_cnt] <= i_sum;
         wr_q.data[i_cnt] <= i_rs2;
      end
   end

   bsc_hs_req #(
      .payload_t (dbus_req_t)
   ) dbus_req_inst (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_start   (i_start),
      .i_payload (wr_q),
      .o_req     (o_dbus_req),
      .o_payload (o_dbus),
      .i_ack     (i_dbus_ack),
      .o_done    (o_done)
   );

endmodule

// File: logic/bsc_rf.sv
`timescale 1ns/1ps
`include "bsc_defines.svh"

module bsc_rf (
   input  logic                   clk,
   input  logic                   i_rst_n,
   input  logic [4:0]             i_cnt,
   input  logic [`BSC_REG_AW-1:0] i_rs1_addr,
   input  logic [`BSC_REG_AW-1:0] i_rs2_addr,
   input  logic [`BSC_REG_AW-1:0] i_rd_addr,
   input  logic                   i_wen,
   input  logic                   i_rd,
   output logic                   o_rs1,
   output logic                   o_rs2
);

   localparam int NREGS = 1 << `BSC_REG_AW;

   logic [`BSC_XLEN-1:0] regs [NREGS];

   // One bit per cycle, bit cnt of rd
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 0; i < NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_wen && i_rd_addr != '0) begin
         regs[i_rd_addr][i_cnt] <= i_rd;
      end
   end

   // x0 reads as zero
   assign o_rs1 = (i_rs1_addr != '0) && regs[i_rs1_addr][i_cnt];
   assign o_rs2 = (i_rs2_addr != '0) && regs[i_rs2_addr][i_cnt];

endmodule

// File: logic/bsc_ctrl.sv
`timescale 1ns/1ps
`include "bsc_defines.svh"

module bsc_ctrl (
   input  logic                 clk,
   input  logic                 i_rst_n,
   input  logic [4:0]           i_cnt,
   input  logic                 i_pcupd,
   input  logic                 i_imm,
   input  logic                 i_take,
   output logic [`BSC_XLEN-1:0] o_pc
);

   logic [`BSC_XLEN-1:0] pc;
   logic                 addend;
   logic                 carry_in;
   logic                 carry_q;
   logic                 sum_bit;

   // Constant 4 has its single set bit at cnt 2
   assign addend   = i_take ? i_imm : (i_cnt == 5'd2);
   assign carry_in = (i_cnt != 5'd0) && carry_q;
   assign sum_bit  = pc[0] ^ addend ^ carry_in;

   // PC rotates right once per cycle, a full word per pass
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc      <= `BSC_RESET_PC;
         carry_q <= 1'b0;
      end else if (i_pcupd) begin
         pc      <= {sum_bit, pc[`BSC_XLEN-1:1]};
         carry_q <= (pc[0] & addend) | (carry_in & (pc[0] ^ addend));
      end
   end

   assign o_pc = pc;

endmodule

// File: logic/bsc_alu.sv
`timescale 1ns/1ps

module bsc_alu
   import bsc_pkg::*;
(
   input  logic       clk,
   input  logic       i_rst_n,
   input  dec_ctrl_t  i_ctrl,
   input  logic [4:0] i_cnt,
   input  logic       i_cnt_en,
   input  logic       i_rs1,
   input  logic       i_rs2,
   input  logic       i_imm,
   output logic       o_rd,
   output logic       o_sum,
   output logic       o_cmp_eq
);

   logic cnt0;
   logic is_sub;
   logic op_b;
   logic b_in;
   logic carry_in;
   logic carry_q;
   logic add_bit;
   logic sum_ci;
   logic sum_cq;
   logic eq_run;
   logic eq_q;
   logic cmp_q;

   assign cnt0   = (i_cnt == 5'd0);
   assign is_sub = (i_ctrl.alu_op == ALU_SUB);
   assign op_b   = i_ctrl.op_b_imm ? i_imm : i_rs2;

   // Two's complement subtract, inverted B and carry seeded to 1
   assign b_in     = op_b ^ is_sub;
   assign carry_in = cnt0 ? is_sub : carry_q;
   assign add_bit  = i_rs1 ^ b_in ^ carry_in;

   // Store address adder
   assign sum_ci = !cnt0 && sum_cq;
   assign o_sum  = i_rs1 ^ i_imm ^ sum_ci;

   assign eq_run = (cnt0 || eq_q) && (i_rs1 == i_rs2);

   always_comb begin
      case (i_ctrl.alu_op)
         ALU_AND:      o_rd = i_rs1 & op_b;
         ALU_OR:       o_rd = i_rs1 | op_b;
         ALU_XOR:      o_rd = i_rs1 ^ op_b;
         ALU_PASS_IMM: o_rd = i_imm;
         default:      o_rd = add_bit;
      endcase
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         carry_q <= 1'b0;
         sum_cq  <= 1'b0;
         eq_q    <= 1'b0;
         cmp_q   <= 1'b0;
      end else if (i_cnt_en) begin
         carry_q <= (i_rs1 & b_in) | (carry_in & (i_rs1 ^ b_in));
         sum_cq  <= (i_rs1 & i_imm) | (sum_ci & (i_rs1 ^ i_imm));
         eq_q    <= eq_run;
         // Result of the last pass, steady through PCUPD
         if (i_cnt == 5'd31) begin
            cmp_q <= eq_run;
         end
      end
   end

   assign o_cmp_eq = cmp_q;

endmodule

// File: logic/bsc_decode.sv
`timescale 1ns/1ps
`include "bsc_defines.svh"

module bsc_decode
   import bsc_pkg::*;
(
   input  logic                 clk,
   input  logic                 i_rst_n,
   input  logic                 i_ir_load,
   input  logic [`BSC_XLEN-1:0] i_ibus_rdata,
   input  phase_e               i_phase,
   input  logic                 i_cnt_en,
   output dec_ctrl_t            o_ctrl,
   output logic                 o_imm
);

   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;

   logic [`BSC_XLEN-1:0] ir;
   logic [`BSC_XLEN-1:0] imm_full;
   logic [`BSC_XLEN-1:0] imm_sh;
   logic [6:0]           opcode;
   logic [2:0]           funct3;
   logic [6:0]           funct7;
   logic                 rd_nz;
   logic                 f3_ok;
   alu_op_e              f3_op;

   assign opcode = ir[6:0];
   assign funct3 = ir[14:12];
   assign funct7 = ir[31:25];
   assign rd_nz  = (ir[11:7] != 5'd0);
   assign f3_ok  = funct3 inside {3'b000, 3'b100, 3'b110, 3'b111};

   // Opcode 0 decodes as a no-op
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         ir <= '0;
      end else if (i_ir_load) begin
         ir <= i_ibus_rdata;
      end
   end

   always_comb begin
      case (funct3)
         3'b100:  f3_op = ALU_XOR;
         3'b110:  f3_op = ALU_OR;
         3'b111:  f3_op = ALU_AND;
         default: f3_op = ALU_ADD;
      endcase
   end

   always_comb begin
      o_ctrl.alu_op    = ALU_ADD;
      o_ctrl.op_b_imm  = 1'b0;
      o_ctrl.rd_wen    = 1'b0;
      o_ctrl.is_branch = 1'b0;
      o_ctrl.branch_ne = 1'b0;
      o_ctrl.is_store  = 1'b0;
      o_ctrl.rs1       = ir[19:15];
      o_ctrl.rs2       = ir[24:20];
      o_ctrl.rd        = ir[11:7];
      imm_full         = '0;
      case (opcode)
         OPC_OP: begin
            // SUB is the only funct7 variant kept
            if (f3_ok && (funct7 == 7'b0000000 ||
                          (funct7 == 7'b0100000 && funct3 == 3'b000))) begin
               o_ctrl.alu_op = funct7[5] ? ALU_SUB : f3_op;
               o_ctrl.rd_wen = rd_nz;
            end
         end
         OPC_OP_IMM: begin
            imm_full        = {{20{ir[31]}}, ir[31:20]};
            o_ctrl.op_b_imm = 1'b1;
            if (f3_ok) begin
               o_ctrl.alu_op = f3_op;
               o_ctrl.rd_wen = rd_nz;
            end
         end
         OPC_LUI: begin
            imm_full      = {ir[31:12], 12'd0};
            o_ctrl.alu_op = ALU_PASS_IMM;
            o_ctrl.rd_wen = rd_nz;
         end
         OPC_BRANCH: begin
            imm_full = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            if (funct3[2:1] == 2'b00) begin
               o_ctrl.is_branch = 1'b1;
               o_ctrl.branch_ne = funct3[0];
            end
         end
         OPC_STORE: begin
            imm_full        = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            o_ctrl.op_b_imm = 1'b1;
            o_ctrl.is_store = (funct3 == 3'b010);
         end
         default: ;
      endcase
   end

   // A full rotation over EXEC leaves the immediate rewound for PCUPD
   always_ff @(posedge clk) begin
      if (i_phase == PH_DECODE) begin
         imm_sh <= imm_full;
      end else if (i_cnt_en) begin
         imm_sh <= {imm_sh[0], imm_sh[`BSC_XLEN-1:1]};
      end
   end

   assign o_imm = imm_sh[0];

endmodule

// File: logic/bsc_state.sv
`timescale 1ns/1ps

module bsc_state
   import bsc_pkg::*;
(
   input  logic      clk,
   input  logic      i_rst_n,
   input  dec_ctrl_t i_ctrl,
   input  logic      i_fetch_done,
   input  logic      i_store_done,
   input  logic      i_ibus_ack,
   output phase_e    o_phase,
   output logic [4:0] o_cnt,
   output logic      o_cnt_en,
   output logic      o_fetch_start,
   output logic      o_store_start,
   output logic      o_ir_load,
   output logic      o_rd_wen
);

   logic started;
   logic ack_q;

   assign o_cnt_en = (o_phase == PH_EXEC) || (o_phase == PH_PCUPD);

   // Load on the first cycle of the instruction ack
   assign o_ir_load = (o_phase == PH_FETCH) && i_ibus_ack && !ack_q;

   assign o_rd_wen = i_ctrl.rd_wen && (o_phase == PH_EXEC);

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_phase       <= PH_FETCH;
         o_cnt         <= 5'd0;
         started       <= 1'b0;
         ack_q         <= 1'b0;
         o_fetch_start <= 1'b0;
         o_store_start <= 1'b0;
      end else begin
         o_fetch_start <= 1'b0;
         o_store_start <= 1'b0;
         ack_q         <= i_ibus_ack;
         // Wraps back to 0 after each 32-cycle pass
         if (o_cnt_en) begin
            o_cnt <= o_cnt + 5'd1;
         end
         case (o_phase)
            PH_FETCH: begin
               if (i_fetch_done) begin
                  started <= 1'b0;
                  o_phase <= PH_DECODE;
               end else if (!started) begin
                  started       <= 1'b1;
                  o_fetch_start <= 1'b1;
               end
            end
            PH_DECODE: o_phase <= PH_EXEC;
            PH_EXEC: begin
               if (o_cnt == 5'd31) begin
                  o_phase <= PH_PCUPD;
               end
            end
            PH_PCUPD: begin
               if (o_cnt == 5'd31) begin
                  o_phase <= i_ctrl.is_store ? PH_STORE : PH_FETCH;
               end
            end
            PH_STORE: begin
               if (i_store_done) begin
                  started <= 1'b0;
                  o_phase <= PH_FETCH;
               end else if (!started) begin
                  started       <= 1'b1;
                  o_store_start <= 1'b1;
               end
            end
            default: o_phase <= PH_FETCH;
         endcase
      end
   end

endmodule

// File: logic/bsc_hs_req.sv
`timescale 1ns/1ps

module bsc_hs_req #(
   parameter type payload_t = logic [31:0]
) (
   input  logic     clk,
   input  logic     i_rst_n,
   input  logic     i_start,
   input  payload_t i_payload,
   output logic     o_req,
   output payload_t o_payload,
   input  logic     i_ack,
   output logic     o_done
);

   typedef enum logic [1:0] {
      HS_IDLE,
      HS_REQ,
      HS_RELEASE
   } hs_state_e;

   hs_state_e state;
   payload_t  payload_q;

   // Payload held from start until the next start
   always_ff @(posedge clk) begin
      if (i_start && state == HS_IDLE) begin
         payload_q <= i_payload;
      end
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state  <= HS_IDLE;
         o_req  <= 1'b0;
         o_done <= 1'b0;
      end else begin
         o_done <= 1'b0;
         case (state)
            HS_IDLE: begin
               if (i_start) begin
                  o_req <= 1'b1;
                  state <= HS_REQ;
               end
            end
            HS_REQ: begin
               if (i_ack) begin
                  o_req <= 1'b0;
                  state <= HS_RELEASE;
               end
            end
            HS_RELEASE: begin
               // Responder still holding ack
               if (!i_ack) begin
                  o_done <= 1'b1;
                  state  <= HS_IDLE;
               end
            end
            default: state <= HS_IDLE;
         endcase
      end
   end

   assign o_payload = payload_q;

endmodule

// File: logic/bsc_pkg.sv
`include "bsc_defines.svh"

package bsc_pkg;

   // Instruction fetch request
   typedef struct packed {
      logic [`BSC_XLEN-1:0] addr;
   } ibus_req_t;

   // Word store request
   typedef struct packed {
      logic [`BSC_XLEN-1:0] addr;
      logic [`BSC_XLEN-1:0] data;
   } dbus_req_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_PASS_IMM
   } alu_op_e;

   typedef struct packed {
      alu_op_e                alu_op;
      logic                   op_b_imm;
      logic                   rd_wen;
      logic                   is_branch;
      logic                   branch_ne;
      logic                   is_store;
      logic [`BSC_REG_AW-1:0] rs1;
      logic [`BSC_REG_AW-1:0] rs2;
      logic [`BSC_REG_AW-1:0] rd;
   } dec_ctrl_t;

   typedef enum logic [2:0] {
      PH_FETCH,
      PH_DECODE,
      PH_EXEC,
      PH_PCUPD,
      PH_STORE
   } phase_e;

endpackage

// File: include/bsc_defines.svh
`ifndef BSC_DEFINES_SVH
`define BSC_DEFINES_SVH

// Machine word width
`define BSC_XLEN 32

// Register index width
`define BSC_REG_AW 5

// First fetch address out of reset
`define BSC_RESET_PC 32'h0000_0000

`endif
